/* common/mem_pkg.sv */
package mem_pkg;

  // bus widths
  localparam int XLEN   = 32;
  localparam int ADDR_W = 32;
  localparam int STRB_W = XLEN / 8;
  localparam int ID_W   = 4;

  // axi4 encodings, single-beat word transfers only
  localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;
  localparam logic [2:0] AXI_SIZE_WORD  = 3'b010; // 4 bytes
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

  // fixed transaction ids per requester
  localparam logic [ID_W-1:0] ID_FETCH = 4'd0;
  localparam logic [ID_W-1:0] ID_DATA  = 4'd1;

  // requester command, wr ignored on the fetch port
  typedef struct packed {
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   wdata;
    logic [STRB_W-1:0] strb;
  } mem_req_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            err;
  } mem_rsp_t;

  // shared by ar and aw
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } axi_ax_t;

  typedef struct packed {
    logic [XLEN-1:0]   data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [XLEN-1:0] data;
    logic [1:0]      resp;
    logic            last;
  } axi_r_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } axi_b_t;

endpackage

/* logic/mem_arbiter.sv */
`timescale 1ns/1ns

module mem_arbiter (
  input  logic              clk,
  input  logic              rst_n_i,

  // instruction fetch port, read only
  input  logic              fetch_req_i,
  input  mem_pkg::mem_req_t fetch_cmd_i,
  output logic              fetch_done_o,
  output mem_pkg::mem_rsp_t fetch_rsp_o,

  // data port, read or write
  input  logic              data_req_i,
  input  mem_pkg::mem_req_t data_cmd_i,
  output logic              data_done_o,
  output mem_pkg::mem_rsp_t data_rsp_o,

  // towards the axi engines
  output logic              rd_start_o,
  output logic              wr_start_o,
  output mem_pkg::axi_ax_t  ax_o,
  output mem_pkg::axi_w_t   w_o,
  input  logic              rd_finish_i,
  input  logic              wr_finish_i,
  input  mem_pkg::mem_rsp_t finish_rsp_i
);

  import mem_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH,
    S_DATA
  } arb_state_e;

  arb_state_e state_q;
  logic       rd_start_q;
  logic       wr_start_q;
  logic       finish;
  mem_req_t   sel_cmd;

  assign finish = rd_finish_i | wr_finish_i;

  // data wins when both ask in the same idle cycle
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= S_IDLE;
      rd_start_q <= 1'b0;
      wr_start_q <= 1'b0;
    end else begin
      rd_start_q <= 1'b0; // single-cycle pulses
      wr_start_q <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (data_req_i) begin
            state_q    <= S_DATA;
            rd_start_q <= ~data_cmd_i.wr;
            wr_start_q <= data_cmd_i.wr;
          end else if (fetch_req_i) begin
            state_q    <= S_FETCH;
            rd_start_q <= 1'b1;
          end
        end
        S_FETCH, S_DATA: begin
          if (finish) begin
            state_q <= S_IDLE; // grant released with the done pulse
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  assign rd_start_o = rd_start_q;
  assign wr_start_o = wr_start_q;

  // requesters hold their command until done, so select from the grant
  assign sel_cmd = (state_q == S_DATA) ? data_cmd_i : fetch_cmd_i;

  always_comb begin
    ax_o.id    = (state_q == S_DATA) ? ID_DATA : ID_FETCH;
    ax_o.addr  = sel_cmd.addr;
    ax_o.len   = AXI_LEN_SINGLE;
    ax_o.size  = AXI_SIZE_WORD;
    ax_o.burst = AXI_BURST_INCR;
  end

  always_comb begin
    w_o.data = sel_cmd.wdata;
    w_o.strb = sel_cmd.strb;
    w_o.last = 1'b1; // every write is one beat
  end

  // finish is already a registered pulse from the engine
  assign fetch_done_o = finish && (state_q == S_FETCH);
  assign data_done_o  = finish && (state_q == S_DATA);
  assign fetch_rsp_o  = finish_rsp_i;
  assign data_rsp_o   = finish_rsp_i;

  // a finish belongs to the granted transaction, one engine at a time
  a_finish_owned: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    finish |-> (state_q != S_IDLE) && !(rd_finish_i && wr_finish_i)
  ) else $error("engine finish with no grant or from both engines");

endmodule

/* axi/axi_read_master.sv */
`timescale 1ns/1ns

module axi_read_master (
  input  logic              clk,
  input  logic              rst_n_i,

  // command from the arbiter
  input  logic              start_i,
  input  mem_pkg::axi_ax_t  ax_i,

  // ar channel
  output logic              ar_valid_o,
  input  logic              ar_ready_i,
  output mem_pkg::axi_ax_t  ar_o,

  // r channel
  input  logic              r_valid_i,
  output logic              r_ready_o,
  input  mem_pkg::axi_r_t   r_i,

  // completion back to the arbiter
  output logic              finish_o,
  output mem_pkg::mem_rsp_t rsp_o
);

  import mem_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_DATA,
    S_DONE
  } rd_state_e;

  rd_state_e       state_q;
  axi_ax_t         ar_q;
  logic [XLEN-1:0] rdata_q;
  logic            err_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            state_q <= S_ADDR;
          end
        end
        S_ADDR: begin
          if (ar_ready_i) begin
            state_q <= S_DATA; // address accepted, wait for the beat
          end
        end
        S_DATA: begin
          if (r_valid_i) begin
            state_q <= S_DONE;
          end
        end
        S_DONE:  state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // address payload held for the whole transaction
  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && start_i) begin
      ar_q <= ax_i;
    end
  end

  // capture the returning beat
  always_ff @(posedge clk) begin
    if (state_q == S_DATA && r_valid_i) begin
      rdata_q <= r_i.data;
      err_q   <= (r_i.resp != AXI_RESP_OKAY); // slverr or decerr
    end
  end

  assign ar_valid_o = (state_q == S_ADDR);
  assign ar_o       = ar_q;
  assign r_ready_o  = (state_q == S_DATA);

  assign finish_o    = (state_q == S_DONE);
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = err_q;

  a_ar_stable: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o)
  ) else $error("ar payload changed before ready");

  // single-beat reads, so the slave must close the burst at once
  a_r_last: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    r_valid_i && r_ready_o |-> r_i.last
  ) else $error("r beat without last on a single-beat read");

endmodule

/* axi/axi_write_master.sv */
`timescale 1ns/1ns

module axi_write_master (
  input  logic              clk,
  input  logic              rst_n_i,

  // command from the arbiter
  input  logic              start_i,
  input  mem_pkg::axi_ax_t  ax_i,
  input  mem_pkg::axi_w_t   w_i,

  // aw channel
  output logic              aw_valid_o,
  input  logic              aw_ready_i,
  output mem_pkg::axi_ax_t  aw_o,

  // w channel
  output logic              w_valid_o,
  input  logic              w_ready_i,
  output mem_pkg::axi_w_t   w_o,

  // b channel
  input  logic              b_valid_i,
  output logic              b_ready_o,
  input  mem_pkg::axi_b_t   b_i,

  // completion back to the arbiter
  output logic              finish_o,
  output mem_pkg::mem_rsp_t rsp_o
);

  import mem_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_RESP,
    S_DONE
  } wr_state_e;

  wr_state_e state_q;
  logic      aw_pend_q; // aw still waiting for ready
  logic      w_pend_q;  // w still waiting for ready
  logic      aw_done;
  logic      w_done;
  axi_ax_t   aw_q;
  axi_w_t    w_q;
  logic      err_q;

  // a channel counts as accepted once its ready has been seen
  assign aw_done = ~aw_pend_q | aw_ready_i;
  assign w_done  = ~w_pend_q | w_ready_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= S_IDLE;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            state_q   <= S_ADDR;
            aw_pend_q <= 1'b1;
            w_pend_q  <= 1'b1;
          end
        end
        S_ADDR: begin
          if (aw_ready_i) begin
            aw_pend_q <= 1'b0;
          end
          if (w_ready_i) begin
            w_pend_q <= 1'b0;
          end
          if (aw_done && w_done) begin
            state_q <= S_RESP; // either order, or both in one edge
          end
        end
        S_RESP: begin
          if (b_valid_i) begin
            state_q <= S_DONE;
          end
        end
        S_DONE:  state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && start_i) begin
      aw_q <= ax_i;
      w_q  <= w_i;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_RESP && b_valid_i) begin
      err_q <= (b_i.resp != AXI_RESP_OKAY);
    end
  end

  assign aw_valid_o = aw_pend_q;
  assign aw_o       = aw_q;
  assign w_valid_o  = w_pend_q;
  assign w_o        = w_q;
  assign b_ready_o  = (state_q == S_RESP);

  assign finish_o    = (state_q == S_DONE);
  assign rsp_o.rdata = '0; // writes return no data
  assign rsp_o.err   = err_q;

  a_w_stable: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o)
  ) else $error("w payload changed before ready");

  a_b_after_aw_w: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    b_ready_o |-> !aw_valid_o && !w_valid_o
  ) else $error("b ready raised with aw or w still outstanding");

endmodule

/* logic/mem_subsys_top.sv */
`timescale 1ns/1ns

module mem_subsys_top (
  input  logic              clk,
  input  logic              rst_n_i,

  // fetch requester
  input  logic              fetch_req_i,
  input  mem_pkg::mem_req_t fetch_cmd_i,
  output logic              fetch_done_o,
  output mem_pkg::mem_rsp_t fetch_rsp_o,

  // data requester
  input  logic              data_req_i,
  input  mem_pkg::mem_req_t data_cmd_i,
  output logic              data_done_o,
  output mem_pkg::mem_rsp_t data_rsp_o,

  // axi4 read side
  output logic              ar_valid_o,
  input  logic              ar_ready_i,
  output mem_pkg::axi_ax_t  ar_o,
  input  logic              r_valid_i,
  output logic              r_ready_o,
  input  mem_pkg::axi_r_t   r_i,

  // axi4 write side
  output logic              aw_valid_o,
  input  logic              aw_ready_i,
  output mem_pkg::axi_ax_t  aw_o,
  output logic              w_valid_o,
  input  logic              w_ready_i,
  output mem_pkg::axi_w_t   w_o,
  input  logic              b_valid_i,
  output logic              b_ready_o,
  input  mem_pkg::axi_b_t   b_i
);

  import mem_pkg::*;

  logic     rd_start;
  logic     wr_start;
  axi_ax_t  arb_ax;
  axi_w_t   arb_w;
  logic     rd_finish;
  logic     wr_finish;
  mem_rsp_t rd_rsp;
  mem_rsp_t wr_rsp;
  mem_rsp_t finish_rsp;

  // only one engine is ever busy
  assign finish_rsp = wr_finish ? wr_rsp : rd_rsp;

  mem_arbiter u_arbiter (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .fetch_req_i  (fetch_req_i),
    .fetch_cmd_i  (fetch_cmd_i),
    .fetch_done_o (fetch_done_o),
    .fetch_rsp_o  (fetch_rsp_o),
    .data_req_i   (data_req_i),
    .data_cmd_i   (data_cmd_i),
    .data_done_o  (data_done_o),
    .data_rsp_o   (data_rsp_o),
    .rd_start_o   (rd_start),
    .wr_start_o   (wr_start),
    .ax_o         (arb_ax),
    .w_o          (arb_w),
    .rd_finish_i  (rd_finish),
    .wr_finish_i  (wr_finish),
    .finish_rsp_i (finish_rsp)
  );

  axi_read_master u_rd (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .start_i    (rd_start),
    .ax_i       (arb_ax),
    .ar_valid_o (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .ar_o       (ar_o),
    .r_valid_i  (r_valid_i),
    .r_ready_o  (r_ready_o),
    .r_i        (r_i),
    .finish_o   (rd_finish),
    .rsp_o      (rd_rsp)
  );

  axi_write_master u_wr (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .start_i    (wr_start),
    .ax_i       (arb_ax),
    .w_i        (arb_w),
    .aw_valid_o (aw_valid_o),
    .aw_ready_i (aw_ready_i),
    .aw_o       (aw_o),
    .w_valid_o  (w_valid_o),
    .w_ready_i  (w_ready_i),
    .w_o        (w_o),
    .b_valid_i  (b_valid_i),
    .b_ready_o  (b_ready_o),
    .b_i        (b_i),
    .finish_o   (wr_finish),
    .rsp_o      (wr_rsp)
  );

endmodule

/* tb/axi_mem_slave.sv */
`timescale 1ns/1ns

module axi_mem_slave (
  input  logic             clk,
  input  logic             rst_n_i,

  input  logic             ar_valid_i,
  output logic             ar_ready_o,
  input  mem_pkg::axi_ax_t ar_i,
  output logic             r_valid_o,
  input  logic             r_ready_i,
  output mem_pkg::axi_r_t  r_o,

  input  logic             aw_valid_i,
  output logic             aw_ready_o,
  input  mem_pkg::axi_ax_t aw_i,
  input  logic             w_valid_i,
  output logic             w_ready_o,
  input  mem_pkg::axi_w_t  w_i,
  output logic             b_valid_o,
  input  logic             b_ready_i,
  output mem_pkg::axi_b_t  b_o
);

  import mem_pkg::*;

  localparam logic [19:0] ERR_PAGE = 20'hF0000; // 4 KiB page answering slverr

  logic [31:0] mem [logic [29:0]]; // sparse, keyed by word address
  logic [31:0] rd_rng = 32'h96be8b85;
  logic [31:0] wr_rng = 32'h96be8b85 ^ 32'h5555_5555; // own stream for the write side
  logic [1:0]  ar_wait, r_wait, aw_wait, w_wait, b_wait;
  logic        rd_pend, aw_got, w_got;
  axi_ax_t     rd_ax, wr_ax;
  axi_w_t      wr_w;

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // unwritten words depend on every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], ~addr[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (mem.exists(addr[31:2])) return mem[addr[31:2]];
    return fill_word(addr);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  // read side: ar ready after 0..3 cycles, then r valid after 0..3 cycles
  always @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      r_o        <= '0;
      rd_pend    <= 1'b0;
      ar_wait    <= 2'd0;
      r_wait     <= 2'd0;
    end else begin
      if (ar_valid_i && ar_ready_o) begin
        ar_ready_o <= 1'b0;
        rd_ax      <= ar_i;
        rd_pend    <= 1'b1;
        rd_rng = next_rand(rd_rng);
        r_wait     <= rd_rng[17:16];
      end else if (ar_valid_i && !rd_pend) begin
        if (ar_wait == 2'd0) ar_ready_o <= 1'b1;
        else ar_wait <= ar_wait - 2'd1;
      end
      if (r_valid_o && r_ready_i) begin
        r_valid_o <= 1'b0;
        rd_pend   <= 1'b0;
        rd_rng = next_rand(rd_rng);
        ar_wait   <= rd_rng[17:16];
      end else if (rd_pend && !r_valid_o) begin
        if (r_wait == 2'd0) begin
          r_valid_o <= 1'b1;
          r_o.id    <= rd_ax.id;
          r_o.data  <= read_word(rd_ax.addr);
          r_o.resp  <= (rd_ax.addr[31:12] == ERR_PAGE) ? 2'b10 : 2'b00;
          r_o.last  <= 1'b1;
        end else begin
          r_wait <= r_wait - 2'd1;
        end
      end
    end
  end

  // write side: aw and w accepted independently, then b
  always @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
      b_valid_o  <= 1'b0;
      b_o        <= '0;
      aw_got     <= 1'b0;
      w_got      <= 1'b0;
      aw_wait    <= 2'd0;
      w_wait     <= 2'd1;
      b_wait     <= 2'd0;
    end else begin
      if (aw_valid_i && aw_ready_o) begin
        aw_ready_o <= 1'b0;
        wr_ax      <= aw_i;
        aw_got     <= 1'b1;
      end else if (aw_valid_i && !aw_got) begin
        if (aw_wait == 2'd0) aw_ready_o <= 1'b1;
        else aw_wait <= aw_wait - 2'd1;
      end
      if (w_valid_i && w_ready_o) begin
        w_ready_o <= 1'b0;
        wr_w      <= w_i;
        w_got     <= 1'b1;
      end else if (w_valid_i && !w_got) begin
        if (w_wait == 2'd0) w_ready_o <= 1'b1;
        else w_wait <= w_wait - 2'd1;
      end
      if (b_valid_o && b_ready_i) begin
        b_valid_o <= 1'b0;
        aw_got    <= 1'b0;
        w_got     <= 1'b0;
        wr_rng = next_rand(wr_rng);
        aw_wait   <= wr_rng[17:16];
        w_wait    <= wr_rng[19:18];
        b_wait    <= wr_rng[21:20];
      end else if (aw_got && w_got && !b_valid_o) begin
        if (b_wait == 2'd0) begin
          b_valid_o <= 1'b1;
          b_o.id    <= wr_ax.id;
          if (wr_ax.addr[31:12] == ERR_PAGE) begin
            b_o.resp <= 2'b10; // error page is never written
          end else begin
            b_o.resp <= 2'b00;
            mem[wr_ax.addr[31:2]] = merge_bytes(read_word(wr_ax.addr), wr_w.data, wr_w.strb);
          end
        end else begin
          b_wait <= b_wait - 2'd1;
        end
      end
    end
  end

endmodule

/* tb/tb_mem_subsys.sv */
`timescale 1ns/1ns

module tb_mem_subsys;

  import mem_pkg::*;

  localparam int          T_CYCLE  = 20;
  localparam int          N_OPS    = 300;
  localparam logic [19:0] ERR_PAGE = 20'hF0000;

  logic     clk;
  logic     rst_n_i;
  logic     fetch_req_i, data_req_i;
  mem_req_t fetch_cmd_i, data_cmd_i;
  logic     fetch_done_o, data_done_o;
  mem_rsp_t fetch_rsp_o, data_rsp_o;
  logic     ar_valid_o, ar_ready_i, r_valid_i, r_ready_o;
  axi_ax_t  ar_o, aw_o;
  axi_r_t   r_i;
  logic     aw_valid_o, aw_ready_i, w_valid_o, w_ready_i, b_valid_i, b_ready_o;
  axi_w_t   w_o;
  axi_b_t   b_i;

  logic [31:0] rng = 32'h96be8b85;
  logic [31:0] ref_mem [logic [29:0]];
  logic [35:0] ax_exp_q[$]; // {id, addr} in issue order
  logic [35:0] w_exp_q[$];  // {data, strb}
  logic        ar_v_q, ar_r_q, aw_v_q, aw_r_q, w_v_q, w_r_q;
  axi_ax_t     ar_q, aw_q;
  axi_w_t      w_q;

  mem_subsys_top DUT (.*);

  axi_mem_slave u_mem (
    .clk        (clk),        .rst_n_i   (rst_n_i),
    .ar_valid_i (ar_valid_o), .ar_ready_o (ar_ready_i), .ar_i (ar_o),
    .r_valid_o  (r_valid_i),  .r_ready_i  (r_ready_o),  .r_o  (r_i),
    .aw_valid_i (aw_valid_o), .aw_ready_o (aw_ready_i), .aw_i (aw_o),
    .w_valid_i  (w_valid_o),  .w_ready_o  (w_ready_i),  .w_i  (w_o),
    .b_valid_o  (b_valid_i),  .b_ready_i  (b_ready_o),  .b_o  (b_i)
  );

  initial begin
    clk = 1'b0;
    forever #(T_CYCLE / 2) clk = ~clk;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected contents of a word never written
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], ~addr[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    if (ref_mem.exists(addr[31:2])) return ref_mem[addr[31:2]];
    return fill_word(addr);
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    logic [31:0] word;
    word = model_read(addr);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) word[8*b +: 8] = data[8*b +: 8];
    end
    ref_mem[addr[31:2]] = word;
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] got);
    if (exp !== got) begin
      $display("error %s expected %h got %h", name, exp, got);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  // mostly a 64-word region for reuse, sometimes the error page
  function automatic mem_req_t rand_cmd();
    mem_req_t c;
    rng = next_rand(rng);
    c.wr = rng[31];
    if (rng[30:28] == 3'd0) c.addr = {ERR_PAGE, rng[11:2], 2'b00};
    else c.addr = 32'h0000_1000 | {rng[21:16], 2'b00};
    rng = next_rand(rng);
    c.wdata = rng;
    rng = next_rand(rng);
    c.strb = rng[19:16];
    return c;
  endfunction

  // address beat check on the handshake edge
  task automatic check_ax(input string name, input axi_ax_t ax);
    logic [35:0] e;
    if (ax_exp_q.size() == 0) fail_now({name, " beat seen with no transaction outstanding"});
    e = ax_exp_q.pop_front();
    check({name, ".id"}, e[35:32], ax.id);
    check({name, ".addr"}, e[31:0], ax.addr);
    check({name, ".len"}, 8'd0, ax.len);
    check({name, ".size"}, 3'b010, ax.size);
    check({name, ".burst"}, 2'b01, ax.burst);
  endtask

  // outputs settle after the rising edge, so watch them on the falling edge
  always @(negedge clk) begin
    if (rst_n_i) begin
      if (ar_v_q && !ar_r_q) begin
        check("ar_valid_o", 1, ar_valid_o);
        check("ar_o", ar_q, ar_o);
      end
      if (aw_v_q && !aw_r_q) begin
        check("aw_valid_o", 1, aw_valid_o);
        check("aw_o", aw_q, aw_o);
      end
      if (w_v_q && !w_r_q) begin
        check("w_valid_o", 1, w_valid_o);
        check("w_o", w_q, w_o);
      end
      if (ar_valid_o && ar_ready_i) check_ax("ar_o", ar_o);
      if (aw_valid_o && aw_ready_i) check_ax("aw_o", aw_o);
      if (w_valid_o && w_ready_i) begin
        if (w_exp_q.size() == 0) fail_now("write data beat seen with no write outstanding");
        check("w_o.data/strb", w_exp_q.pop_front(), {w_o.data, w_o.strb});
        check("w_o.last", 1, w_o.last);
      end
      if (data_done_o && !data_req_i) fail_now("data done pulse without a data request");
      if (fetch_done_o && !fetch_req_i) fail_now("fetch done pulse without a fetch request");
      ar_v_q = ar_valid_o;
      ar_r_q = ar_ready_i;
      ar_q   = ar_o;
      aw_v_q = aw_valid_o;
      aw_r_q = aw_ready_i;
      aw_q   = aw_o;
      w_v_q  = w_valid_o;
      w_r_q  = w_ready_i;
      w_q    = w_o;
    end
  end

  task automatic run_op();
    mem_req_t    dcmd, fcmd;
    logic        use_d, use_f, pend_d, pend_f;
    logic        d_err, f_err;
    logic [31:0] d_data, f_data;
    rng = next_rand(rng);
    use_d = (rng[17:16] != 2'd0); // 0 fetch, 1 data, 2..3 both
    use_f = (rng[17:16] != 2'd1);
    dcmd  = rand_cmd();
    fcmd  = rand_cmd();
    d_err = (dcmd.addr[31:12] == ERR_PAGE);
    f_err = (fcmd.addr[31:12] == ERR_PAGE);
    d_data = '0;
    // data goes first when both ask together
    if (use_d) begin
      ax_exp_q.push_back({ID_DATA, dcmd.addr});
      if (dcmd.wr) begin
        w_exp_q.push_back({dcmd.wdata, dcmd.strb});
        if (!d_err) model_write(dcmd.addr, dcmd.wdata, dcmd.strb);
      end else begin
        d_data = model_read(dcmd.addr);
      end
    end
    if (use_f) ax_exp_q.push_back({ID_FETCH, fcmd.addr});
    f_data = model_read(fcmd.addr);
    @(posedge clk);
    data_req_i  <= use_d;
    data_cmd_i  <= dcmd;
    fetch_req_i <= use_f;
    fetch_cmd_i <= fcmd;
    pend_d = use_d;
    pend_f = use_f;
    while (pend_d || pend_f) begin
      @(negedge clk);
      if (data_done_o) begin
        check("data_rsp_o.err", d_err, data_rsp_o.err);
        if (!dcmd.wr && !d_err) check("data_rsp_o.rdata", d_data, data_rsp_o.rdata);
        pend_d = 1'b0;
      end
      if (fetch_done_o) begin
        if (pend_d) fail_now("fetch done arrived before the data done");
        check("fetch_rsp_o.err", f_err, fetch_rsp_o.err);
        if (!f_err) check("fetch_rsp_o.rdata", f_data, fetch_rsp_o.rdata);
        pend_f = 1'b0;
      end
      @(posedge clk);
      if (!pend_d) data_req_i <= 1'b0;
      if (!pend_f) fetch_req_i <= 1'b0;
    end
  endtask

  initial begin
    rst_n_i     = 1'b0;
    fetch_req_i = 1'b0;
    data_req_i  = 1'b0;
    fetch_cmd_i = '0;
    data_cmd_i  = '0;
    ar_v_q = 1'b0;
    ar_r_q = 1'b0;
    aw_v_q = 1'b0;
    aw_r_q = 1'b0;
    w_v_q  = 1'b0;
    w_r_q  = 1'b0;
    repeat (3) @(posedge clk);
    rst_n_i <= 1'b1;
    repeat (2) begin
      @(negedge clk);
      check("idle outputs", 0, {ar_valid_o, aw_valid_o, w_valid_o, r_ready_o, b_ready_o,
                                fetch_done_o, data_done_o});
    end
    for (int i = 0; i < N_OPS; i++) begin
      run_op();
    end
    repeat (5) @(posedge clk);
    if (ax_exp_q.size() != 0 || w_exp_q.size() != 0) begin
      $display("transactions expected on the bus never appeared");
      $display("TEST FAIL");
      $fatal(1);
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

  // each op issues at most two transactions
  initial begin
    #(T_CYCLE * 200 * 2 * N_OPS + T_CYCLE * 100);
    $display("timeout, a request never received its done pulse");
    $display("TEST FAIL");
    $fatal(1);
  end

endmodule

/* sources.f */
common/mem_pkg.sv
logic/mem_arbiter.sv
axi/axi_read_master.sv
axi/axi_write_master.sv
logic/mem_subsys_top.sv
tb/axi_mem_slave.sv
tb/tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - common/mem_pkg.sv
  - logic/mem_arbiter.sv
  - axi/axi_read_master.sv
  - axi/axi_write_master.sv
  - logic/mem_subsys_top.sv
  - target: test
    files:
      - tb/axi_mem_slave.sv
      - tb/tb_mem_subsys.sv
